//--- status_mon_top.f
+incdir+dv
source/status_mon_pkg.sv
source/status_capture.sv
source/status_xfer.sv
source/status_regmap.sv
source/status_mon_top.sv
dv/status_mon_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the status monitor testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module status_mon_tb -f status_mon_top.f -o status_mon_sim
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

./obj_dir/status_mon_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Some tests failed" "$log"; then
  exit 1
fi
if ! grep -q "All tests passed" "$log"; then
  echo "simulation log holds no final result"
  exit 1
fi
exit 0

//--- dv/status_tb_tasks.svh
`ifndef status_tb_tasks_svh
`define status_tb_tasks_svh

// ------------------------------------------------------------
// register bus access
// ------------------------------------------------------------

task automatic bus_read(input logic [reg_addr_width-1:0] addr, output logic [7:0] data);
  int waited;
  @(posedge up_clk);
  #2;
  up_rreq  = 1'b1;
  up_raddr = addr;
  @(posedge up_clk);
  #2;
  up_rreq = 1'b0;
  waited  = 0;
  while (!up_rack && waited < bus_timeout) begin
    @(posedge up_clk);
    #2;
    waited++;
  end
  if (!up_rack) begin
    $display("read of register %0d was never acknowledged", addr);
    err_count++;
    data = '0;
  end else begin
    data = up_rdata;
  end
endtask

task automatic bus_write(input logic [reg_addr_width-1:0] addr, input logic [7:0] data);
  int waited;
  @(posedge up_clk);
  #2;
  up_wreq  = 1'b1;
  up_waddr = addr;
  up_wdata = data;
  @(posedge up_clk);
  #2;
  up_wreq = 1'b0;
  waited  = 0;
  while (!up_wack && waited < bus_timeout) begin
    @(posedge up_clk);
    #2;
    waited++;
  end
  if (!up_wack) begin
    $display("write to register %0d was never acknowledged", addr);
    err_count++;
  end
endtask

// polls a register until all of the given bits are set.
task automatic wait_for_bits(input logic [reg_addr_width-1:0] addr, input logic [7:0] bits,
                             output logic [7:0] data);
  int polls;
  polls = 0;
  bus_read(addr, data);
  while (((data & bits) != bits) && polls < poll_limit) begin
    bus_read(addr, data);
    polls++;
  end
  if ((data & bits) != bits) begin
    $display("timed out waiting for bits %02h in register %0d", bits, addr);
    err_count++;
  end
endtask

`endif

//--- dv/status_mon_tb.sv
`timescale 1ns/1ps

module status_mon_tb;

  import status_mon_pkg::*;

  localparam int bus_timeout = 8;
  localparam int poll_limit = 200;

  logic                            d_clk;
  logic                            d_rst;
  logic [num_channels-1:0]         d_chan_enable;
  chan_status_t [num_channels-1:0] d_event;
  logic                            up_clk;
  logic                            up_rst;
  logic                            up_rreq;
  logic [reg_addr_width-1:0]       up_raddr;
  logic                            up_rack;
  chan_status_t                    up_rdata;
  logic                            up_wreq;
  logic [reg_addr_width-1:0]       up_waddr;
  chan_status_t                    up_wdata;
  logic                            up_wack;

  int     err_count;
  int     err_at_start;
  int     pass_count;
  int     fail_count;
  int     protocol_errs = 0;
  integer seed;
  logic   rreq_prev = 1'b0;
  logic   wreq_prev = 1'b0;

  `include "status_tb_tasks.svh"

  status_mon_top i_status_mon_top (
    .d_clk         (d_clk),
    .d_rst         (d_rst),
    .d_chan_enable (d_chan_enable),
    .d_event       (d_event),
    .up_clk        (up_clk),
    .up_rst        (up_rst),
    .up_rreq       (up_rreq),
    .up_raddr      (up_raddr),
    .up_rack       (up_rack),
    .up_rdata      (up_rdata),
    .up_wreq       (up_wreq),
    .up_waddr      (up_waddr),
    .up_wdata      (up_wdata),
    .up_wack       (up_wack)
  );

  initial begin
    d_clk = 1'b0;
    forever #10 d_clk = ~d_clk;
  end

  initial begin
    up_clk = 1'b0;
    forever #13 up_clk = ~up_clk;
  end

  // acks follow their request by exactly one up_clk cycle.
  // read data stays zero outside the ack cycle.
  always @(posedge up_clk) begin
    if (!up_rst) begin
      assert (up_rack == rreq_prev) else begin
        $display("ERROR: %0t up_rack is %b one cycle after up_rreq %b",
                 $time, up_rack, rreq_prev);
        protocol_errs++;
      end
      assert (up_wack == wreq_prev) else begin
        $display("ERROR: %0t up_wack is %b one cycle after up_wreq %b",
                 $time, up_wack, wreq_prev);
        protocol_errs++;
      end
      assert (up_rack || (up_rdata == '0)) else begin
        $display("ERROR: %0t up_rdata is %02h while up_rack is low", $time, up_rdata);
        protocol_errs++;
      end
    end
    rreq_prev <= up_rreq;
    wreq_prev <= up_wreq;
  end

  // ------------------------------------------------------------
  // checks and reporting
  // ------------------------------------------------------------

  function automatic logic [reg_addr_width-1:0] chan_reg(input int ch);
    return reg_addr_chan_base + reg_addr_width'(ch);
  endfunction

  task automatic expect_word(input string what, input logic [7:0] actual,
                             input logic [7:0] expected);
    assert (actual == expected) else begin
      $display("ERROR: %0t %s expected %02h got %02h", $time, what, expected, actual);
      err_count++;
    end
  endtask

  task automatic expect_reg(input logic [reg_addr_width-1:0] addr, input logic [7:0] expected);
    logic [7:0] data;
    bus_read(addr, data);
    expect_word($sformatf("register %0d", addr), data, expected);
  endtask

  // repeated reads must keep returning the same word.
  task automatic expect_steady(input logic [reg_addr_width-1:0] addr, input logic [7:0] expected,
                               input int reads);
    for (int i = 0; i < reads; i++) begin
      expect_reg(addr, expected);
    end
  endtask

  task automatic pulse_event(input int ch, input logic [7:0] word);
    @(posedge d_clk);
    #2;
    d_event[ch] = word;
    @(posedge d_clk);
    #2;
    d_event[ch] = '0;
  endtask

  task automatic wait_windows(input int windows);
    for (int i = 0; i < windows * xfer_window; i++) begin
      @(posedge d_clk);
    end
  endtask

  task automatic start_test();
    err_at_start = err_count;
  endtask

  task automatic finish_test(input string name);
    if (err_count == err_at_start) begin
      pass_count++;
      $display("[ok]   %s", name);
    end else begin
      fail_count++;
      $display("[fail] %s", name);
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------

  initial begin
    logic [7:0] data;
    logic [7:0] flag_mask;
    int         ch;
    int         flag_bit;
    d_rst         = 1'b1;
    up_rst        = 1'b1;
    d_chan_enable = '1;
    d_event       = '0;
    up_rreq       = 1'b0;
    up_raddr      = '0;
    up_wreq       = 1'b0;
    up_waddr      = '0;
    up_wdata      = '0;
    err_count     = 0;
    err_at_start  = 0;
    pass_count    = 0;
    fail_count    = 0;
    seed          = 99;

    fork
      begin
        repeat (5) @(posedge d_clk);
        #2;
        d_rst = 1'b0;
      end
      begin
        repeat (5) @(posedge up_clk);
        #2;
        up_rst = 1'b0;
      end
    join

    start_test();
    expect_reg(reg_addr_summary, 8'h00);
    for (int k = 0; k < num_channels; k++) begin
      expect_reg(chan_reg(k), 8'h00);
    end
    finish_test("reset values");

    start_test();
    ch        = $unsigned($random(seed)) % num_channels;
    flag_bit  = $unsigned($random(seed)) % 8;
    flag_mask = 8'h01 << flag_bit;
    pulse_event(ch, flag_mask);
    wait_for_bits(chan_reg(ch), flag_mask, data);
    for (int k = 0; k < num_channels; k++) begin
      expect_reg(chan_reg(k), (k == ch) ? flag_mask : 8'h00);
    end
    expect_reg(reg_addr_summary, 8'h01 << ch);
    bus_write(chan_reg(ch), flag_mask);
    expect_reg(chan_reg(ch), 8'h00);
    finish_test("single random flag");

    start_test();
    pulse_event(2, 8'hc3);
    wait_for_bits(chan_reg(2), 8'hc3, data);
    bus_write(chan_reg(2), 8'h81);
    expect_reg(chan_reg(2), 8'h42);
    expect_steady(chan_reg(2), 8'h42, 40);
    bus_write(chan_reg(2), 8'h42);
    expect_reg(chan_reg(2), 8'h00);
    finish_test("write one to clear");

    start_test();
    @(posedge d_clk);
    #2;
    d_event[1] = 8'h08;
    wait_for_bits(chan_reg(1), 8'h08, data);
    bus_write(chan_reg(1), 8'h08);
    expect_reg(chan_reg(1), 8'h00);
    wait_for_bits(chan_reg(1), 8'h08, data);
    expect_word("held flag after clear", data, 8'h08);
    @(posedge d_clk);
    #2;
    d_event[1] = '0;
    wait_windows(3);
    bus_write(chan_reg(1), 8'h08);
    expect_reg(chan_reg(1), 8'h00);
    finish_test("held flag returns");

    start_test();
    @(posedge d_clk);
    #2;
    d_chan_enable[3] = 1'b0;
    pulse_event(3, 8'hff);
    // pn_err together with pn_oos.
    pulse_event(1, 8'h30);
    wait_for_bits(chan_reg(1), 8'h10, data);
    wait_windows(3);
    expect_reg(chan_reg(3), 8'h00);
    expect_reg(chan_reg(1), 8'h10);
    expect_reg(reg_addr_summary, 8'h02);
    bus_write(chan_reg(1), 8'h10);
    @(posedge d_clk);
    #2;
    d_chan_enable[3] = 1'b1;
    finish_test("channel mask and pn qualify");

    start_test();
    pulse_event(0, 8'h01);
    wait_for_bits(chan_reg(0), 8'h01, data);
    for (int a = num_channels + 1; a < 16; a++) begin
      bus_write(reg_addr_width'(a), 8'hff);
      expect_reg(reg_addr_width'(a), 8'h00);
    end
    expect_reg(chan_reg(0), 8'h01);
    expect_reg(reg_addr_summary, 8'h01);
    finish_test("unmapped addresses");

    $display("%0d tests ok, %0d tests with errors, %0d bus protocol errors",
             pass_count, fail_count, protocol_errs);
    if (fail_count == 0 && protocol_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- source/status_mon_top.sv
`timescale 1ns/1ps

module status_mon_top (
  input  logic                                                         d_clk,
  input  logic                                                         d_rst,
  input  logic [status_mon_pkg::num_channels-1:0]                      d_chan_enable,
  input  status_mon_pkg::chan_status_t [status_mon_pkg::num_channels-1:0] d_event,
  input  logic                                                         up_clk,
  input  logic                                                         up_rst,
  input  logic                                                         up_rreq,
  input  logic [status_mon_pkg::reg_addr_width-1:0]                    up_raddr,
  output logic                                                         up_rack,
  output status_mon_pkg::chan_status_t                                 up_rdata,
  input  logic                                                         up_wreq,
  input  logic [status_mon_pkg::reg_addr_width-1:0]                    up_waddr,
  input  status_mon_pkg::chan_status_t                                 up_wdata,
  output logic                                                         up_wack
);

  import status_mon_pkg::*;

  chan_status_t [num_channels-1:0] d_status;
  xfer_status_t [num_channels-1:0] up_xfer;

  status_capture i_status_capture (
    .d_clk         (d_clk),
    .d_rst         (d_rst),
    .d_chan_enable (d_chan_enable),
    .d_event       (d_event),
    .d_status      (d_status)
  );

  // one crossing per channel.
  for (genvar k = 0; k < num_channels; k++) begin : g_xfer
    status_xfer i_status_xfer (
      .d_clk    (d_clk),
      .d_rst    (d_rst),
      .d_status (d_status[k]),
      .up_clk   (up_clk),
      .up_rst   (up_rst),
      .up_xfer  (up_xfer[k])
    );
  end

  status_regmap i_status_regmap (
    .up_clk   (up_clk),
    .up_rst   (up_rst),
    .up_xfer  (up_xfer),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rack  (up_rack),
    .up_rdata (up_rdata),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack)
  );

endmodule

//--- source/status_regmap.sv
`timescale 1ns/1ps

module status_regmap (
  input  logic                                                         up_clk,
  input  logic                                                         up_rst,
  input  status_mon_pkg::xfer_status_t [status_mon_pkg::num_channels-1:0] up_xfer,
  input  logic                                                         up_rreq,
  input  logic [status_mon_pkg::reg_addr_width-1:0]                    up_raddr,
  output logic                                                         up_rack,
  output status_mon_pkg::chan_status_t                                 up_rdata,
  input  logic                                                         up_wreq,
  input  logic [status_mon_pkg::reg_addr_width-1:0]                    up_waddr,
  input  status_mon_pkg::chan_status_t                                 up_wdata,
  output logic                                                         up_wack
);

  import status_mon_pkg::*;

  chan_status_t [num_channels-1:0] sticky;
  chan_status_t [num_channels-1:0] sticky_set;
  chan_status_t [num_channels-1:0] sticky_clr;
  logic [$bits(chan_status_t)-1:0] summary;
  chan_status_t                    rd_word;

  function automatic logic [reg_addr_width-1:0] chan_addr(input int k);
    return reg_addr_chan_base + reg_addr_width'(k);
  endfunction

  // ------------------------------------------------------------
  // sticky set and clear terms
  // ------------------------------------------------------------

  always_comb begin
    for (int k = 0; k < num_channels; k++) begin
      sticky_set[k] = up_xfer[k].valid ? up_xfer[k].status : '0;
      sticky_clr[k] = (up_wreq && (up_waddr == chan_addr(k))) ? up_wdata : '0;
    end
  end

  // one bit per channel, upper bits stay zero.
  always_comb begin
    summary = '0;
    for (int k = 0; k < num_channels; k++) begin
      summary[k] = |sticky[k];
    end
  end

  // read decode. unmapped addresses fall through to zero.
  always_comb begin
    rd_word = '0;
    if (up_raddr == reg_addr_summary) begin
      rd_word = chan_status_t'(summary);
    end
    for (int k = 0; k < num_channels; k++) begin
      if (up_raddr == chan_addr(k)) begin
        rd_word = sticky[k];
      end
    end
  end

  // ------------------------------------------------------------
  // registers and bus response
  // ------------------------------------------------------------

  always_ff @(posedge up_clk) begin
    if (up_rst) begin
      sticky   <= '0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
      up_wack  <= 1'b0;
    end else begin
      // a new event wins over a clear in the same cycle.
      for (int k = 0; k < num_channels; k++) begin
        sticky[k] <= (sticky[k] & ~sticky_clr[k]) | sticky_set[k];
      end
      up_rack  <= up_rreq;
      up_rdata <= up_rreq ? rd_word : '0;
      up_wack  <= up_wreq;
    end
  end

endmodule

//--- source/status_xfer.sv
`timescale 1ns/1ps

module status_xfer (
  input  logic                          d_clk,
  input  logic                          d_rst,
  input  status_mon_pkg::chan_status_t  d_status,
  input  logic                          up_clk,
  input  logic                          up_rst,
  output status_mon_pkg::xfer_status_t  up_xfer
);

  import status_mon_pkg::*;

  // d_clk side.
  logic                      d_rtn_m1;
  logic                      d_rtn_m2;
  logic                      d_rtn;
  logic [xfer_cnt_width-1:0] d_cnt;
  logic                      d_tgl;
  logic                      d_send;
  chan_status_t              d_acc;
  chan_status_t              d_hold;

  // up_clk side.
  logic                      up_tgl_m1;
  logic                      up_tgl_m2;
  logic                      up_tgl_m3;
  logic                      up_edge;
  logic                      up_valid;
  chan_status_t              up_data;

  // ------------------------------------------------------------
  // d_clk domain, window accumulation and toggle launch
  // ------------------------------------------------------------

  // send at the end of a window, and only once the previous word was taken.
  assign d_send = (d_cnt == '1) && (d_rtn == d_tgl);

  always_ff @(posedge d_clk) begin
    if (d_rst) begin
      d_rtn_m1 <= 1'b0;
      d_rtn_m2 <= 1'b0;
      d_rtn    <= 1'b0;
      d_cnt    <= '0;
      d_tgl    <= 1'b0;
      d_acc    <= '0;
    end else begin
      d_rtn_m1 <= up_tgl_m3;
      d_rtn_m2 <= d_rtn_m1;
      d_rtn    <= d_rtn_m2;
      d_cnt    <= d_cnt + 1'b1;
      if (d_send) begin
        d_tgl <= ~d_tgl;
        // new window starts with this cycle's flags.
        d_acc <= d_status;
      end else begin
        d_acc <= d_acc | d_status;
      end
    end
  end

  // held stable until the return toggle comes back.
  always_ff @(posedge d_clk) begin
    if (d_send) begin
      d_hold <= d_acc;
    end
  end

  // ------------------------------------------------------------
  // up_clk domain, toggle detect and capture
  // ------------------------------------------------------------

  assign up_edge = up_tgl_m3 ^ up_tgl_m2;

  always_ff @(posedge up_clk) begin
    if (up_rst) begin
      up_tgl_m1 <= 1'b0;
      up_tgl_m2 <= 1'b0;
      up_tgl_m3 <= 1'b0;
      up_valid  <= 1'b0;
    end else begin
      up_tgl_m1 <= d_tgl;
      up_tgl_m2 <= up_tgl_m1;
      up_tgl_m3 <= up_tgl_m2;
      up_valid  <= up_edge;
    end
  end

  always_ff @(posedge up_clk) begin
    if (up_edge) begin
      up_data <= d_hold;
    end
  end

  assign up_xfer = '{valid: up_valid, status: up_data};

endmodule

//--- source/status_capture.sv
`timescale 1ns/1ps

module status_capture (
  input  logic                                                         d_clk,
  input  logic                                                         d_rst,
  input  logic [status_mon_pkg::num_channels-1:0]                      d_chan_enable,
  input  status_mon_pkg::chan_status_t [status_mon_pkg::num_channels-1:0] d_event,
  output status_mon_pkg::chan_status_t [status_mon_pkg::num_channels-1:0] d_status
);

  import status_mon_pkg::*;

  chan_status_t [num_channels-1:0] d_qual;

  // a disabled channel reports nothing.
  // pn errors only count while the pn checker is in sync.
  function automatic chan_status_t qualify(input chan_status_t raw, input logic en);
    chan_status_t word;
    word = raw;
    if (word.pn_oos) begin
      word.pn_err = 1'b0;
    end
    if (!en) begin
      word = '0;
    end
    return word;
  endfunction

  always_comb begin
    for (int k = 0; k < num_channels; k++) begin
      d_qual[k] = qualify(d_event[k], d_chan_enable[k]);
    end
  end

  // ------------------------------------------------------------
  // input register
  // ------------------------------------------------------------

  always_ff @(posedge d_clk) begin
    if (d_rst) begin
      d_status <= '0;
    end else begin
      d_status <= d_qual;
    end
  end

endmodule

//--- source/status_mon_pkg.sv
package status_mon_pkg;

  // ------------------------------------------------------------
  // sizing
  // ------------------------------------------------------------

  localparam int num_channels = 4;

  // accumulation window in d_clk cycles.
  localparam int xfer_window = 64;
  localparam int xfer_cnt_width = $clog2(xfer_window);

  // ------------------------------------------------------------
  // status words
  // ------------------------------------------------------------

  // per-channel condition flags, over_range is the msb.
  typedef struct packed {
    logic over_range;
    logic under_range;
    logic pn_err;
    logic pn_oos;
    logic fifo_ovf;
    logic fifo_unf;
    logic sync_lost;
    logic clk_lost;
  } chan_status_t;

  // word delivered into the up_clk domain, valid is a one-cycle strobe.
  typedef struct packed {
    logic         valid;
    chan_status_t status;
  } xfer_status_t;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------

  localparam int reg_addr_width = 4;

  localparam logic [reg_addr_width-1:0] reg_addr_summary = reg_addr_width'(0);
  localparam logic [reg_addr_width-1:0] reg_addr_chan_base = reg_addr_width'(1);

endpackage
